// File: sim.f
+incdir+design
design/axi_pkg.sv
design/aw_route.sv
design/w_route.sv
design/b_merge.sv
design/axi_wr_bridge.sv
bench/axi_wr_bridge_sva.sv
bench/tb_axi_wr_bridge.sv

// File: Makefile
TOP = tb_axi_wr_bridge

.PHONY: sim clean

sim:
	verilator --binary --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_axi_wr_bridge.sv
module tb_axi_wr_bridge
  import axi_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int NROWS          = 7;
  localparam int MAX_ROW_CYCLES = 80;  // 16 stalled beats plus address and response

  localparam axi_size_t  BEAT_SIZE  = 3'd2;
  localparam axi_burst_t BURST_INCR = 2'b01;

  typedef struct packed {
    axi_addr_t  addr;
    axi_id_t    id;
    axi_len_t   len;
    slave_sel_t sel;
    axi_resp_t  resp;
    logic       early;  // Offer another address during the response wait
  } row_t;

  row_t rows [NROWS] = '{
    '{addr: 32'h0000_0100, id: 4'h3, len: 4'd0,  sel: SLAVE_0,   resp: RESP_OKAY,   early: 1'b0},
    '{addr: 32'h0001_0040, id: 4'h5, len: 4'd3,  sel: SLAVE_1,   resp: RESP_OKAY,   early: 1'b1},
    '{addr: 32'h0002_0000, id: 4'h9, len: 4'd2,  sel: SLAVE_DEF, resp: RESP_DECERR, early: 1'b0},
    '{addr: 32'h0000_1ff0, id: 4'h0, len: 4'd7,  sel: SLAVE_0,   resp: RESP_OKAY,   early: 1'b0},
    '{addr: 32'h0001_fffc, id: 4'hf, len: 4'd1,  sel: SLAVE_1,   resp: RESP_OKAY,   early: 1'b0},
    '{addr: 32'h8000_0000, id: 4'h6, len: 4'd0,  sel: SLAVE_DEF, resp: RESP_DECERR, early: 1'b1},
    '{addr: 32'h0000_0008, id: 4'ha, len: 4'd15, sel: SLAVE_0,   resp: RESP_OKAY,   early: 1'b0}
  };

  logic     clk;
  logic     rstn;
  aw_m_t    aw_m;
  logic     aw_valid, aw_ready;
  w_beat_t  w;
  logic     w_valid, w_ready;
  b_m_t     b;
  logic     b_valid, b_ready;
  aw_s_t    s0_aw, s1_aw;
  logic     s0_aw_valid, s0_aw_ready, s1_aw_valid, s1_aw_ready;
  w_beat_t  s0_w, s1_w;
  logic     s0_w_valid, s0_w_ready, s1_w_valid, s1_w_ready;
  b_s_t     s0_b, s1_b;
  logic     s0_b_valid, s0_b_ready, s1_b_valid, s1_b_ready;
  int       seed = 32'he309_5aa8;
  int       checks = 0;
  int       errors = 0;
  axi_ids_t slave_ids;  // Id as the addressed slave took it

  axi_wr_bridge #(
    .S0_BASE    (32'h0000_0000),
    .S1_BASE    (32'h0001_0000),
    .REGION_BITS(16)
  ) i_axi_wr_bridge (
    .clk, .rstn, .aw_m, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
    .b, .b_valid, .b_ready,
    .s0_aw, .s0_aw_valid, .s0_aw_ready, .s0_w, .s0_w_valid, .s0_w_ready,
    .s0_b, .s0_b_valid, .s0_b_ready,
    .s1_aw, .s1_aw_valid, .s1_aw_ready, .s1_w, .s1_w_valid, .s1_w_ready,
    .s1_b, .s1_b_valid, .s1_b_ready
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int pick_delay(input int max);
    return $unsigned($random(seed)) % (max + 1);
  endfunction

  task automatic check_aw(input string name, input aw_s_t got, input aw_s_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_w(input string name, input w_beat_t got, input w_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_b(input string name, input b_m_t got, input b_m_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic send_addr(input row_t r);
    aw_s_t exp;
    int    delay;
    int    n;
    exp = '{ids: {AXI_MASTER_1_ID, r.id}, addr: r.addr, len: r.len,
            size: BEAT_SIZE, burst: BURST_INCR};
    delay = pick_delay(3);
    n = 0;
    @(negedge clk);
    aw_m = '{id: r.id, addr: r.addr, len: r.len, size: BEAT_SIZE, burst: BURST_INCR};
    aw_valid = 1'b1;
    forever begin
      s0_aw_ready = (r.sel != SLAVE_0) || (n >= delay);  // Other slave stays ready to catch a leak
      s1_aw_ready = (r.sel != SLAVE_1) || (n >= delay);
      @(posedge clk);
      check_valid("s0_aw_valid", s0_aw_valid, r.sel == SLAVE_0);
      check_valid("s1_aw_valid", s1_aw_valid, r.sel == SLAVE_1);
      check_valid("aw_ready", aw_ready, (r.sel == SLAVE_DEF) || (n >= delay));
      if (r.sel == SLAVE_0) check_aw("s0_aw", s0_aw, exp);
      if (r.sel == SLAVE_1) check_aw("s1_aw", s1_aw, exp);
      if (aw_ready) break;
      @(negedge clk);
      n++;
    end
    slave_ids = (r.sel == SLAVE_1) ? s1_aw.ids : s0_aw.ids;
    @(negedge clk);
    aw_valid    = 1'b0;
    s0_aw_ready = 1'b0;
    s1_aw_ready = 1'b0;
  endtask

  task automatic send_beats(input row_t r);
    w_beat_t beat;
    int      nbeats;
    int      k;
    int      delay;
    int      n;
    nbeats = int'(r.len) + 1;
    for (k = 0; k < nbeats; k++) begin
      beat = '{data: axi_data_t'($random(seed)), strb: 4'hf, last: (k == nbeats - 1)};
      delay = pick_delay(2);
      n = 0;
      @(negedge clk);
      w = beat;
      w_valid = 1'b1;
      forever begin
        s0_w_ready = (n >= delay);
        s1_w_ready = (n >= delay);
        @(posedge clk);
        check_valid("s0_w_valid", s0_w_valid, r.sel == SLAVE_0);
        check_valid("s1_w_valid", s1_w_valid, r.sel == SLAVE_1);
        check_valid("w_ready", w_ready, (r.sel == SLAVE_DEF) || (n >= delay));
        check_valid("b_valid", b_valid, 1'b0);
        if (r.sel == SLAVE_0) check_w("s0_w", s0_w, beat);
        if (r.sel == SLAVE_1) check_w("s1_w", s1_w, beat);
        if (w_ready) break;
        @(negedge clk);
        n++;
      end
    end
    @(negedge clk);
    w_valid    = 1'b0;
    s0_w_ready = 1'b0;
    s1_w_ready = 1'b0;
  endtask

  task automatic wait_resp(input row_t r);
    b_m_t exp;
    int   bdelay;
    int   rdelay;
    int   n;
    exp = '{id: r.id, resp: r.resp};
    bdelay = pick_delay(4);
    rdelay = pick_delay(3);
    n = 0;
    forever begin
      @(negedge clk);
      s0_b       = '{ids: slave_ids, resp: RESP_OKAY};
      s1_b       = '{ids: slave_ids, resp: RESP_OKAY};
      s0_b_valid = (r.sel == SLAVE_0) && (n >= bdelay);
      s1_b_valid = (r.sel == SLAVE_1) && (n >= bdelay);
      b_ready    = (n >= rdelay);
      if (r.early) begin
        aw_m = '{id: ~r.id, addr: r.addr ^ 32'h0000_0040, len: 4'd0,
                 size: BEAT_SIZE, burst: BURST_INCR};
        aw_valid = 1'b1;
      end
      @(posedge clk);
      check_valid("aw_ready", aw_ready, 1'b0);  // No new address until b completes
      check_valid("s0_aw_valid", s0_aw_valid, 1'b0);
      check_valid("s1_aw_valid", s1_aw_valid, 1'b0);
      check_valid("b_valid", b_valid, (r.sel == SLAVE_DEF) || (n >= bdelay));
      check_valid("s0_b_ready", s0_b_ready, (r.sel == SLAVE_0) && b_ready);
      check_valid("s1_b_ready", s1_b_ready, (r.sel == SLAVE_1) && b_ready);
      if (b_valid && b_ready) break;
      n++;
    end
    check_b("b", b, exp);
    @(negedge clk);
    aw_valid   = 1'b0;
    s0_b_valid = 1'b0;
    s1_b_valid = 1'b0;
    b_ready    = 1'b0;
  endtask

  // Watchdog
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NROWS * MAX_ROW_CYCLES));
    $display("Timeout: the rows did not finish within %0d cycles",
             RESET_CYCLES + NROWS * MAX_ROW_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int i;
    int row_errors;
    int sva_fails;
    rstn        = 1'b0;
    aw_m        = '0;
    aw_valid    = 1'b0;
    w           = '0;
    w_valid     = 1'b0;
    b_ready     = 1'b0;
    s0_aw_ready = 1'b0;
    s0_w_ready  = 1'b0;
    s0_b        = '0;
    s0_b_valid  = 1'b0;
    s1_aw_ready = 1'b0;
    s1_w_ready  = 1'b0;
    s1_b        = '0;
    s1_b_valid  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    @(posedge clk);
    check_valid("aw_ready", aw_ready, 1'b0);
    check_valid("w_ready", w_ready, 1'b0);
    check_valid("b_valid", b_valid, 1'b0);
    check_valid("s0_aw_valid", s0_aw_valid, 1'b0);
    check_valid("s1_aw_valid", s1_aw_valid, 1'b0);

    for (i = 0; i < NROWS; i++) begin
      row_errors = errors;
      send_addr(rows[i]);
      send_beats(rows[i]);
      wait_resp(rows[i]);
      $display("Row %0d addr %h id %h len %0d: %s", i, rows[i].addr, rows[i].id,
               rows[i].len, (errors == row_errors) ? "ok" : "mismatch");
    end

    sva_fails = i_axi_wr_bridge.i_axi_wr_bridge_sva.fail_count;
    $display("Rows %0d, checks %0d, errors %0d, assertion failures %0d",
             NROWS, checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: bench/axi_wr_bridge_sva.sv
module axi_wr_bridge_sva
  import axi_pkg::*;
(
  input logic  clk,
  input logic  rstn,
  input aw_s_t s0_aw,
  input logic  s0_aw_valid,
  input logic  s0_aw_ready,
  input aw_s_t s1_aw,
  input logic  s1_aw_valid,
  input logic  s1_aw_ready,
  input logic  def_aw_valid,
  input logic  s0_w_valid,
  input logic  s1_w_valid,
  input logic  s0_b_valid,
  input logic  s0_b_ready,
  input logic  s1_b_valid,
  input logic  s1_b_ready
);

  logic s0_open;  // Address taken, response still due
  logic s1_open;
  int   s0_hold_errs = 0;
  int   s1_hold_errs = 0;
  int   onehot_errs  = 0;
  int   order_errs   = 0;
  int   fail_count;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s0_open <= 1'b0;
      s1_open <= 1'b0;
    end else begin
      if (s0_aw_valid && s0_aw_ready) s0_open <= 1'b1;
      else if (s0_b_valid && s0_b_ready) s0_open <= 1'b0;
      if (s1_aw_valid && s1_aw_ready) s1_open <= 1'b1;
      else if (s1_b_valid && s1_b_ready) s1_open <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (!rstn)
    (s0_aw_valid && !s0_aw_ready) |=> (s0_aw_valid && $stable(s0_aw)))
    else begin
      $error("s0 address dropped or changed while stalled");
      s0_hold_errs++;
    end

  assert property (@(posedge clk) disable iff (!rstn)
    (s1_aw_valid && !s1_aw_ready) |=> (s1_aw_valid && $stable(s1_aw)))
    else begin
      $error("s1 address dropped or changed while stalled");
      s1_hold_errs++;
    end

  assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s0_aw_valid, s1_aw_valid, def_aw_valid}) && $onehot0({s0_w_valid, s1_w_valid}))
    else begin
      $error("More than one slave valid at once");
      onehot_errs++;
    end

  // Data only after the slave took its address
  assert property (@(posedge clk) disable iff (!rstn)
    (!s0_w_valid || s0_open) && (!s1_w_valid || s1_open))
    else begin
      $error("Write data reached a slave before its address");
      order_errs++;
    end

  assign fail_count = s0_hold_errs + s1_hold_errs + onehot_errs + order_errs;

endmodule

bind axi_wr_bridge axi_wr_bridge_sva i_axi_wr_bridge_sva (
  .clk, .rstn,
  .s0_aw, .s0_aw_valid, .s0_aw_ready,
  .s1_aw, .s1_aw_valid, .s1_aw_ready,
  .def_aw_valid,
  .s0_w_valid, .s1_w_valid,
  .s0_b_valid, .s0_b_ready, .s1_b_valid, .s1_b_ready
);

// File: design/axi_wr_bridge.sv
module axi_wr_bridge
  import axi_pkg::*;
#(
  parameter axi_addr_t S0_BASE     = 32'h0000_0000,
  parameter axi_addr_t S1_BASE     = 32'h0001_0000,
  parameter int        REGION_BITS = 16
) (
  input  logic    clk,
  input  logic    rstn,
  // Master
  input  aw_m_t   aw_m,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  w_beat_t w,
  input  logic    w_valid,
  output logic    w_ready,
  output b_m_t    b,
  output logic    b_valid,
  input  logic    b_ready,
  // Slave 0
  output aw_s_t   s0_aw,
  output logic    s0_aw_valid,
  input  logic    s0_aw_ready,
  output w_beat_t s0_w,
  output logic    s0_w_valid,
  input  logic    s0_w_ready,
  input  b_s_t    s0_b,
  input  logic    s0_b_valid,
  output logic    s0_b_ready,
  // Slave 1
  output aw_s_t   s1_aw,
  output logic    s1_aw_valid,
  input  logic    s1_aw_ready,
  output w_beat_t s1_w,
  output logic    s1_w_valid,
  input  logic    s1_w_ready,
  input  b_s_t    s1_b,
  input  logic    s1_b_valid,
  output logic    s1_b_ready
);

  aw_s_t      def_aw;  // Carries the id for DECERR
  logic       def_aw_valid;
  logic       def_aw_ready;
  logic       aw_grant;
  slave_sel_t grant_sel;
  slave_sel_t resp_sel;
  logic       w_idle;
  logic       last_done;
  logic       b_done;

  aw_route #(
    .S0_BASE    (S0_BASE),
    .S1_BASE    (S1_BASE),
    .REGION_BITS(REGION_BITS)
  ) i_aw_route (
    .clk, .rstn, .aw_m, .aw_valid, .aw_ready, .w_idle,
    .s0_aw, .s0_aw_valid, .s0_aw_ready,
    .s1_aw, .s1_aw_valid, .s1_aw_ready,
    .def_aw, .def_aw_valid, .def_aw_ready,
    .aw_grant, .grant_sel
  );

  w_route i_w_route (
    .clk, .rstn, .aw_grant, .grant_sel, .w, .w_valid, .w_ready,
    .s0_w, .s0_w_valid, .s0_w_ready,
    .s1_w, .s1_w_valid, .s1_w_ready,
    .b_done, .w_idle, .last_done, .resp_sel
  );

  b_merge i_b_merge (
    .clk, .rstn, .resp_sel, .last_done,
    .def_aw, .def_aw_valid, .def_aw_ready,
    .s0_b, .s0_b_valid, .s0_b_ready,
    .s1_b, .s1_b_valid, .s1_b_ready,
    .b, .b_valid, .b_ready, .b_done
  );

endmodule

// File: design/b_merge.sv
`include "axi_define.svh"

module b_merge
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  slave_sel_t resp_sel,
  input  logic       last_done,
  // Default slave address sink
  input  aw_s_t      def_aw,
  input  logic       def_aw_valid,
  output logic       def_aw_ready,
  // Slave responses
  input  b_s_t       s0_b,
  input  logic       s0_b_valid,
  output logic       s0_b_ready,
  input  b_s_t       s1_b,
  input  logic       s1_b_valid,
  output logic       s1_b_ready,
  // Master
  output b_m_t       b,
  output logic       b_valid,
  input  logic       b_ready,
  output logic       b_done
);

  axi_id_t def_id;
  logic    wait_b;  // Last beat taken, response pending

  assign def_aw_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (def_aw_valid && def_aw_ready) begin
      def_id <= def_aw.ids[`AXI_ID_BITS-1:0];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wait_b <= 1'b0;
    end else if (last_done) begin
      wait_b <= 1'b1;
    end else if (b_done) begin
      wait_b <= 1'b0;
    end
  end

  // Strip the master prefix on the way back
  always_comb begin
    b_valid    = 1'b0;
    b          = '{id: def_id, resp: RESP_DECERR};
    s0_b_ready = 1'b0;
    s1_b_ready = 1'b0;
    if (wait_b) begin
      case (resp_sel)
        SLAVE_0: begin
          b_valid    = s0_b_valid;
          b          = '{id: s0_b.ids[`AXI_ID_BITS-1:0], resp: s0_b.resp};
          s0_b_ready = b_ready;
        end
        SLAVE_1: begin
          b_valid    = s1_b_valid;
          b          = '{id: s1_b.ids[`AXI_ID_BITS-1:0], resp: s1_b.resp};
          s1_b_ready = b_ready;
        end
        default: b_valid = 1'b1;  // DECERR, one cycle after last beat
      endcase
    end
  end

  assign b_done = b_valid && b_ready;

endmodule

// File: design/w_route.sv
module w_route
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // Address grant
  input  logic       aw_grant,
  input  slave_sel_t grant_sel,
  // Master
  input  w_beat_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  // Slaves
  output w_beat_t    s0_w,
  output logic       s0_w_valid,
  input  logic       s0_w_ready,
  output w_beat_t    s1_w,
  output logic       s1_w_valid,
  input  logic       s1_w_ready,
  // Response side
  input  logic       b_done,
  output logic       w_idle,
  output logic       last_done,
  output slave_sel_t resp_sel
);

  w_phase_t   phase;
  w_phase_t   phase_next;
  slave_sel_t sel_r;  // Slave of the granted burst

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase <= PHASE_IDLE;
      sel_r <= SLAVE_0;
    end else begin
      phase <= phase_next;
      if (aw_grant) begin
        sel_r <= grant_sel;
      end
    end
  end

  always_comb begin
    phase_next = phase;
    case (phase)
      PHASE_IDLE: begin
        if (aw_grant) phase_next = PHASE_DATA;
      end
      PHASE_DATA: begin
        if (last_done) phase_next = PHASE_RESP;
      end
      PHASE_RESP: begin
        if (b_done) phase_next = PHASE_IDLE;
      end
      default: phase_next = PHASE_IDLE;
    endcase
  end

  // Beats pass only after their address
  always_comb begin
    s0_w_valid = 1'b0;
    s1_w_valid = 1'b0;
    w_ready    = 1'b0;
    if (phase == PHASE_DATA) begin
      case (sel_r)
        SLAVE_0: begin
          s0_w_valid = w_valid;
          w_ready    = s0_w_ready;
        end
        SLAVE_1: begin
          s1_w_valid = w_valid;
          w_ready    = s1_w_ready;
        end
        default: w_ready = 1'b1;  // Default slave sinks everything
      endcase
    end
  end

  assign s0_w = w;
  assign s1_w = w;

  assign last_done = (phase == PHASE_DATA) && w_valid && w_ready && w.last;
  assign w_idle    = (phase == PHASE_IDLE);
  assign resp_sel  = sel_r;

endmodule

// File: design/aw_route.sv
`include "axi_define.svh"

module aw_route
  import axi_pkg::*;
#(
  parameter axi_addr_t S0_BASE     = 32'h0000_0000,
  parameter axi_addr_t S1_BASE     = 32'h0001_0000,
  parameter int        REGION_BITS = 16
) (
  input  logic       clk,
  input  logic       rstn,
  // Master
  input  aw_m_t      aw_m,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  logic       w_idle,
  // Slave 0
  output aw_s_t      s0_aw,
  output logic       s0_aw_valid,
  input  logic       s0_aw_ready,
  // Slave 1
  output aw_s_t      s1_aw,
  output logic       s1_aw_valid,
  input  logic       s1_aw_ready,
  // Default slave
  output aw_s_t      def_aw,
  output logic       def_aw_valid,
  input  logic       def_aw_ready,
  // To the data and response side
  output logic       aw_grant,
  output slave_sel_t grant_sel
);

  aw_lock_t   lock;
  aw_lock_t   lock_next;
  aw_s_t      aw_live;
  aw_s_t      aw_hold;
  aw_s_t      aw_out;
  slave_sel_t sel;
  logic       fast;
  logic       slow;
  logic       out_valid;
  logic       sel_ready;

  function automatic slave_sel_t decode(axi_addr_t addr);
    if (addr[`AXI_ADDR_BITS-1 -: REGION_BITS] == S0_BASE[`AXI_ADDR_BITS-1 -: REGION_BITS])
      return SLAVE_0;
    if (addr[`AXI_ADDR_BITS-1 -: REGION_BITS] == S1_BASE[`AXI_ADDR_BITS-1 -: REGION_BITS])
      return SLAVE_1;
    return SLAVE_DEF;  // Unmapped space
  endfunction

  // Prefix the master number onto the id
  assign aw_live = '{
    ids:   {AXI_MASTER_1_ID, aw_m.id},
    addr:  aw_m.addr,
    len:   aw_m.len,
    size:  aw_m.size,
    burst: aw_m.burst
  };

  assign fast      = (lock == LOCK_FREE) && w_idle && aw_valid;
  assign slow      = (lock == LOCK_M1);
  assign aw_out    = slow ? aw_hold : aw_live;  // Latched copy while stalled
  assign out_valid = fast || slow;
  assign sel       = decode(aw_out.addr);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_FREE;
    end else begin
      lock <= lock_next;
    end
  end

  always_comb begin
    lock_next = lock;
    case (lock)
      LOCK_FREE: begin
        if (fast && !sel_ready) lock_next = LOCK_M1;
      end
      LOCK_M1: begin
        if (sel_ready) lock_next = LOCK_FREE;
      end
      default: lock_next = LOCK_FREE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fast && !sel_ready) begin
      aw_hold <= aw_live;
    end
  end

  // Only the chosen slave's ready goes back
  always_comb begin
    case (sel)
      SLAVE_0: sel_ready = s0_aw_ready;
      SLAVE_1: sel_ready = s1_aw_ready;
      default: sel_ready = def_aw_ready;
    endcase
  end

  assign s0_aw  = aw_out;
  assign s1_aw  = aw_out;
  assign def_aw = aw_out;

  assign s0_aw_valid  = out_valid && (sel == SLAVE_0);
  assign s1_aw_valid  = out_valid && (sel == SLAVE_1);
  assign def_aw_valid = out_valid && (sel == SLAVE_DEF);

  assign aw_grant  = out_valid && sel_ready;  // Transfer edge
  assign aw_ready  = aw_grant;
  assign grant_sel = sel;

endmodule

// File: design/axi_pkg.sv
`include "axi_define.svh"

package axi_pkg;

  typedef logic [`AXI_ID_BITS-1:0]     axi_id_t;
  typedef logic [`AXI_IDS_BITS-1:0]    axi_ids_t;    // {master, id}
  typedef logic [`AXI_ADDR_BITS-1:0]   axi_addr_t;
  typedef logic [`AXI_LEN_BITS-1:0]    axi_len_t;
  typedef logic [`AXI_SIZE_BITS-1:0]   axi_size_t;
  typedef logic [1:0]                  axi_burst_t;
  typedef logic [`AXI_DATA_BITS-1:0]   axi_data_t;
  typedef logic [`AXI_DATA_BITS/8-1:0] axi_strb_t;
  typedef logic [1:0]                  axi_resp_t;

  localparam logic [3:0] AXI_MASTER_1_ID = 4'h1;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  typedef enum logic [1:0] {SLAVE_0, SLAVE_1, SLAVE_DEF} slave_sel_t;

  typedef enum logic {LOCK_FREE, LOCK_M1} aw_lock_t;

  typedef enum logic [1:0] {PHASE_IDLE, PHASE_DATA, PHASE_RESP} w_phase_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } aw_m_t;

  // Same fields toward a slave
  typedef struct packed {
    axi_ids_t   ids;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } aw_s_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_beat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_m_t;

  typedef struct packed {
    axi_ids_t  ids;
    axi_resp_t resp;
  } b_s_t;

endpackage

// File: design/axi_define.svh
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Master side id, the slave side id adds a master prefix
`define AXI_ID_BITS    4
`define AXI_IDS_BITS   8

`define AXI_ADDR_BITS  32
`define AXI_LEN_BITS   4   // Beats minus one
`define AXI_SIZE_BITS  3

`define AXI_DATA_BITS  32

`endif
